// File: logic/recovery_pkg.sv
// Recovery command codes, protocol error codes, register map, lookup tables and payload types
package recovery_pkg;

  typedef logic [31:0] word_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } resp_beat_t;

  typedef enum logic [7:0] {
    CMD_PROT_CAP        = 8'd34,
    CMD_DEVICE_ID       = 8'd35,
    CMD_DEVICE_STATUS   = 8'd36,
    CMD_DEVICE_RESET    = 8'd37,
    CMD_RECOVERY_CTRL   = 8'd38,
    CMD_RECOVERY_STATUS = 8'd39,
    CMD_HW_STATUS       = 8'd40
  } cmd_e;

  typedef enum logic [7:0] {
    PROTO_OK        = 8'd0,
    PROTO_READ_ONLY = 8'd1,
    PROTO_PARAMETER = 8'd2,
    PROTO_LENGTH    = 8'd3,
    PROTO_CRC       = 8'd4
  } proto_err_e;

  typedef enum logic [3:0] {
    CSR_PROT_CAP_0      = 4'd0,
    CSR_PROT_CAP_1      = 4'd1,
    CSR_PROT_CAP_2      = 4'd2,
    CSR_PROT_CAP_3      = 4'd3,
    CSR_DEVICE_ID_0     = 4'd4,
    CSR_DEVICE_ID_1     = 4'd5,
    CSR_DEVICE_STATUS   = 4'd6,
    CSR_DEVICE_RESET    = 4'd7,
    CSR_RECOVERY_CTRL   = 4'd8,
    CSR_RECOVERY_STATUS = 4'd9,
    CSR_HW_STATUS       = 4'd10
  } csr_idx_e;

  localparam int unsigned NUM_CSR = 11;
  localparam int unsigned NUM_CMD = 7;

  // Tables indexed by command code minus CMD_PROT_CAP
  localparam csr_idx_e CMD_BASE [NUM_CMD] = '{
    CSR_PROT_CAP_0, CSR_DEVICE_ID_0, CSR_DEVICE_STATUS, CSR_DEVICE_RESET,
    CSR_RECOVERY_CTRL, CSR_RECOVERY_STATUS, CSR_HW_STATUS
  };
  localparam logic [15:0] CMD_LEN [NUM_CMD] = '{
    16'd15, 16'd8, 16'd4, 16'd3, 16'd3, 16'd2, 16'd4
  };
  // Only DEVICE_RESET and RECOVERY_CTRL accept writes
  localparam logic [NUM_CMD-1:0] CMD_WRITEABLE = 7'b001_1000;

  // "OCP RECV" magic, version and capabilities
  localparam word_t PROT_CAP_VALUE [4] = '{
    32'h2050_434F, 32'h5643_4552, 32'h0003_0101, 32'h0000_1000
  };
  localparam word_t DEVICE_ID_VALUE [2] = '{32'h0400_00FF, 32'h0001_5A3C};

  localparam word_t HW_STATUS_RESET       = 32'h0000_1E02;
  localparam word_t RECOVERY_STATUS_RESET = 32'h0000_0011;

  localparam int unsigned RX_DEPTH = 8;
  localparam int unsigned TX_DEPTH = 16;

endpackage

// File: logic/recovery_cmd_if.sv
// Command interface between frame receiver and command executor
`timescale 1ns/1ps

interface recovery_cmd_if;
  logic                     valid;
  logic                     is_rd;
  recovery_pkg::cmd_e       cmd;
  // Length field of the frame in bytes
  logic [15:0]              len;
  recovery_pkg::proto_err_e err;
  logic                     done;

  modport source (output valid, is_rd, cmd, len, err, input done);
  modport sink (input valid, is_rd, cmd, len, err, output done);
endinterface

// File: logic/recovery_fifo.sv
// Synchronous valid/ready FIFO with a type parameter and a flush
`timescale 1ns/1ps

module recovery_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  payload_t                 mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;
  logic                     push;
  logic                     pop;

  assign in_ready_o  = count_q < DEPTH;
  assign out_valid_o = count_q != '0;
  assign out_data_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

// File: logic/recovery_csr_file.sv
// Recovery register file with read-only constants and the protocol status byte
`timescale 1ns/1ps

module recovery_csr_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_en_i,
  input  recovery_pkg::csr_idx_e   wr_idx_i,
  input  recovery_pkg::word_t      wr_data_i,
  input  recovery_pkg::csr_idx_e   rd_idx_i,
  output recovery_pkg::word_t      rd_data_o,
  input  logic                     status_we_i,
  input  recovery_pkg::proto_err_e status_err_i
);

  recovery_pkg::proto_err_e status_q;
  recovery_pkg::word_t      device_reset_q;
  recovery_pkg::word_t      recovery_ctrl_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      status_q        <= recovery_pkg::PROTO_OK;
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
    end else begin
      if (wr_en_i) begin
        case (wr_idx_i)
          recovery_pkg::CSR_DEVICE_RESET:  device_reset_q <= wr_data_i;
          recovery_pkg::CSR_RECOVERY_CTRL: recovery_ctrl_q <= wr_data_i;
          default: ;
        endcase
      end
      if (status_we_i) begin
        status_q <= status_err_i;
      end
    end
  end

  always_comb begin
    case (rd_idx_i)
      recovery_pkg::CSR_PROT_CAP_0:      rd_data_o = recovery_pkg::PROT_CAP_VALUE[0];
      recovery_pkg::CSR_PROT_CAP_1:      rd_data_o = recovery_pkg::PROT_CAP_VALUE[1];
      recovery_pkg::CSR_PROT_CAP_2:      rd_data_o = recovery_pkg::PROT_CAP_VALUE[2];
      recovery_pkg::CSR_PROT_CAP_3:      rd_data_o = recovery_pkg::PROT_CAP_VALUE[3];
      recovery_pkg::CSR_DEVICE_ID_0:     rd_data_o = recovery_pkg::DEVICE_ID_VALUE[0];
      recovery_pkg::CSR_DEVICE_ID_1:     rd_data_o = recovery_pkg::DEVICE_ID_VALUE[1];
      // Protocol status lives in byte 1
      recovery_pkg::CSR_DEVICE_STATUS:   rd_data_o = {16'h0000, status_q, 8'h00};
      recovery_pkg::CSR_DEVICE_RESET:    rd_data_o = device_reset_q;
      recovery_pkg::CSR_RECOVERY_CTRL:   rd_data_o = recovery_ctrl_q;
      recovery_pkg::CSR_RECOVERY_STATUS: rd_data_o = recovery_pkg::RECOVERY_STATUS_RESET;
      recovery_pkg::CSR_HW_STATUS:       rd_data_o = recovery_pkg::HW_STATUS_RESET;
      default:                           rd_data_o = '0;
    endcase
  end

endmodule

// File: logic/recovery_receiver.sv
// Host frame parser with checksum and length check, and byte-to-word packer
`timescale 1ns/1ps

module recovery_receiver (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                host_valid_i,
  output logic                host_ready_o,
  input  logic [7:0]          host_data_i,
  input  logic                host_first_i,
  input  logic                host_rd_i,
  input  logic                host_last_i,
  output logic                word_valid_o,
  input  logic                word_ready_i,
  output recovery_pkg::word_t word_data_o,
  recovery_cmd_if.source      cmd
);

  typedef enum logic [2:0] {StCmd, StLenLo, StLenHi, StData, StBusy} state_e;

  state_e                   state_q;
  logic                     beat;
  logic                     room;
  logic                     issue;
  logic                     push_word;
  recovery_pkg::proto_err_e issue_err;
  logic [7:0]               csum_q;
  logic [15:0]              len_q;
  logic [15:0]              byte_cnt_q;
  recovery_pkg::word_t      word_q;
  logic                     word_valid_q;
  logic                     cmd_valid_q;
  logic                     cmd_rd_q;
  recovery_pkg::cmd_e       cmd_code_q;
  recovery_pkg::proto_err_e cmd_err_q;

  // Host stalls on an outstanding command or a word waiting for queue space
  assign host_ready_o = (state_q != StBusy) && (!word_valid_q || word_ready_i);
  assign beat         = host_valid_i && host_ready_o;

  // Bytes past the queue capacity are checked but not stored
  assign room = byte_cnt_q < 16'(recovery_pkg::RX_DEPTH * 4);

  assign push_word = beat && (state_q == StData) && room &&
                     (host_last_i ? (byte_cnt_q[1:0] != 2'd0) : (byte_cnt_q[1:0] == 2'd3));

  // Frame end and the error found so far
  always_comb begin
    issue     = 1'b0;
    issue_err = recovery_pkg::PROTO_OK;
    if (beat) begin
      case (state_q)
        StCmd: begin
          if (host_first_i && (host_rd_i || host_last_i)) begin
            issue     = 1'b1;
            issue_err = host_rd_i ? recovery_pkg::PROTO_OK : recovery_pkg::PROTO_LENGTH;
          end
        end
        StLenLo, StLenHi: begin
          issue     = host_last_i;
          issue_err = recovery_pkg::PROTO_LENGTH;
        end
        StData: begin
          issue = host_last_i;
          if (host_data_i != csum_q) begin
            issue_err = recovery_pkg::PROTO_CRC;
          end else if (byte_cnt_q != len_q) begin
            issue_err = recovery_pkg::PROTO_LENGTH;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= StCmd;
      cmd_valid_q  <= 1'b0;
      word_valid_q <= 1'b0;
      byte_cnt_q   <= '0;
    end else begin
      if (push_word) begin
        word_valid_q <= 1'b1;
      end else if (word_ready_i) begin
        word_valid_q <= 1'b0;
      end
      if (issue) begin
        cmd_valid_q <= 1'b1;
        state_q     <= StBusy;
      end else if (cmd.done) begin
        cmd_valid_q <= 1'b0;
        state_q     <= StCmd;
      end else if (beat) begin
        case (state_q)
          StCmd: begin
            if (host_first_i) begin
              state_q    <= StLenLo;
              byte_cnt_q <= '0;
            end
          end
          StLenLo: state_q <= StLenHi;
          StLenHi: state_q <= StData;
          StData:  byte_cnt_q <= byte_cnt_q + 16'd1;
          default: ;
        endcase
      end
    end
  end

  // Running XOR, length field and little-endian packing
  always_ff @(posedge clk_i) begin
    if (beat) begin
      csum_q <= (state_q == StCmd) ? host_data_i : (csum_q ^ host_data_i);
      case (state_q)
        StCmd: begin
          cmd_code_q <= recovery_pkg::cmd_e'(host_data_i);
          cmd_rd_q   <= host_rd_i;
          len_q      <= '0;
        end
        StLenLo: len_q[7:0] <= host_data_i;
        StLenHi: len_q[15:8] <= host_data_i;
        StData: begin
          if (!host_last_i) begin
            if (byte_cnt_q[1:0] == 2'd0) begin
              word_q <= {24'h0, host_data_i};
            end else begin
              word_q[8*byte_cnt_q[1:0] +: 8] <= host_data_i;
            end
          end
        end
        default: ;
      endcase
    end
    if (issue) begin
      cmd_err_q <= issue_err;
    end
  end

  assign word_valid_o = word_valid_q;
  assign word_data_o  = word_q;
  assign cmd.valid    = cmd_valid_q;
  assign cmd.is_rd    = cmd_rd_q;
  assign cmd.cmd      = cmd_code_q;
  assign cmd.len      = len_q;
  assign cmd.err      = cmd_err_q;

endmodule

// File: logic/recovery_executor.sv
// Command FSM for register writes, read responses and protocol status update
`timescale 1ns/1ps

module recovery_executor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  recovery_cmd_if.sink             cmd,
  input  logic                     rx_valid_i,
  output logic                     rx_ready_o,
  input  recovery_pkg::word_t      rx_data_i,
  output logic                     rx_flush_o,
  output logic                     wr_en_o,
  output recovery_pkg::csr_idx_e   wr_idx_o,
  output recovery_pkg::word_t      wr_data_o,
  output recovery_pkg::csr_idx_e   rd_idx_o,
  input  recovery_pkg::word_t      rd_data_i,
  output logic                     status_we_o,
  output recovery_pkg::proto_err_e status_err_o,
  output logic                     tx_valid_o,
  input  logic                     tx_ready_i,
  output recovery_pkg::resp_beat_t tx_data_o
);

  typedef enum logic [2:0] {
    Idle, Write, Drain, ReadLenLo, ReadLenHi, ReadData, Done, Error
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  logic                     known;
  logic [2:0]               tbl;
  logic [15:0]              reg_len;
  recovery_pkg::proto_err_e err_d;
  recovery_pkg::proto_err_e err_q;
  recovery_pkg::csr_idx_e   idx_q;
  // Words left to write, or length then bytes left to read
  logic [15:0]              cnt_q;
  logic [1:0]               lane_q;
  logic                     rx_fire;

  // Command table lookup
  assign known = (cmd.cmd >= recovery_pkg::CMD_PROT_CAP) &&
                 (cmd.cmd <= recovery_pkg::CMD_HW_STATUS);
  assign tbl     = known ? 3'(cmd.cmd - recovery_pkg::CMD_PROT_CAP) : 3'd0;
  assign reg_len = known ? recovery_pkg::CMD_LEN[tbl] : 16'd0;

  // Receiver errors take priority over decode errors
  always_comb begin
    if (cmd.err != recovery_pkg::PROTO_OK) begin
      err_d = cmd.err;
    end else if (!known) begin
      err_d = recovery_pkg::PROTO_PARAMETER;
    end else if (!cmd.is_rd && !recovery_pkg::CMD_WRITEABLE[tbl]) begin
      err_d = recovery_pkg::PROTO_READ_ONLY;
    end else if (!cmd.is_rd && (cmd.len > reg_len)) begin
      err_d = recovery_pkg::PROTO_LENGTH;
    end else begin
      err_d = recovery_pkg::PROTO_OK;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd.valid) begin
          if (cmd.is_rd) begin
            state_d = ReadLenLo;
          end else if (err_d != recovery_pkg::PROTO_OK) begin
            state_d = Error;
          end else if (cmd.len == 16'd0) begin
            state_d = Done;
          end else begin
            state_d = Write;
          end
        end
      end
      Write:     if (rx_fire && (cnt_q == 16'd1)) state_d = Done;
      Error:     state_d = Drain;
      // Wait for the flushed queue to read empty
      Drain:     if (!rx_valid_i) state_d = Done;
      ReadLenLo: if (tx_ready_i) state_d = ReadLenHi;
      ReadLenHi: if (tx_ready_i) state_d = (cnt_q == 16'd0) ? Done : ReadData;
      ReadData:  if (tx_ready_i && (cnt_q == 16'd1)) state_d = Done;
      Done:      state_d = Idle;
      default:   state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      Idle: begin
        if (cmd.valid) begin
          idx_q  <= recovery_pkg::CMD_BASE[tbl];
          cnt_q  <= cmd.is_rd ? reg_len : ((cmd.len + 16'd3) >> 2);
          lane_q <= '0;
          err_q  <= err_d;
        end
      end
      Write: begin
        if (rx_fire) begin
          idx_q <= recovery_pkg::csr_idx_e'(idx_q + 4'd1);
          cnt_q <= cnt_q - 16'd1;
        end
      end
      ReadData: begin
        if (tx_ready_i) begin
          lane_q <= lane_q + 2'd1;
          cnt_q  <= cnt_q - 16'd1;
          if (lane_q == 2'd3) begin
            idx_q <= recovery_pkg::csr_idx_e'(idx_q + 4'd1);
          end
        end
      end
      default: ;
    endcase
  end

  assign rx_ready_o = (state_q == Write);
  assign rx_fire    = rx_valid_i && rx_ready_o;
  assign rx_flush_o = (state_q == Error);

  assign wr_en_o   = rx_fire;
  assign wr_idx_o  = idx_q;
  assign wr_data_o = rx_data_i;
  assign rd_idx_o  = idx_q;

  assign status_we_o  = (state_q == Done);
  assign status_err_o = err_q;
  assign cmd.done     = (state_q == Done);

  // Response beats: length low, length high, then register bytes
  always_comb begin
    tx_valid_o     = 1'b0;
    tx_data_o.data = cnt_q[7:0];
    tx_data_o.last = 1'b0;
    case (state_q)
      ReadLenLo: tx_valid_o = 1'b1;
      ReadLenHi: begin
        tx_valid_o     = 1'b1;
        tx_data_o.data = cnt_q[15:8];
        tx_data_o.last = (cnt_q == 16'd0);
      end
      ReadData: begin
        tx_valid_o     = 1'b1;
        tx_data_o.data = rd_data_i[8*lane_q +: 8];
        tx_data_o.last = (cnt_q == 16'd1);
      end
      default: ;
    endcase
  end

endmodule

// File: logic/recovery_top.sv
// Recovery command layer top level wiring receiver, RX and TX queues, executor and registers
`timescale 1ns/1ps

module recovery_top (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       host_valid_i,
  output logic       host_ready_o,
  input  logic [7:0] host_data_i,
  input  logic       host_first_i,
  input  logic       host_rd_i,
  input  logic       host_last_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output logic [7:0] resp_data_o,
  output logic       resp_last_o
);

  logic                     rx_in_valid;
  logic                     rx_in_ready;
  recovery_pkg::word_t      rx_in_data;
  logic                     rx_out_valid;
  logic                     rx_out_ready;
  recovery_pkg::word_t      rx_out_data;
  logic                     rx_flush;
  logic                     tx_in_valid;
  logic                     tx_in_ready;
  recovery_pkg::resp_beat_t tx_in_data;
  recovery_pkg::resp_beat_t tx_out_data;
  logic                     wr_en;
  recovery_pkg::csr_idx_e   wr_idx;
  recovery_pkg::word_t      wr_data;
  recovery_pkg::csr_idx_e   rd_idx;
  recovery_pkg::word_t      rd_data;
  logic                     status_we;
  recovery_pkg::proto_err_e status_err;

  recovery_cmd_if cmd_if ();

  recovery_receiver receiver_i (
    .clk_i, .rst_ni,
    .host_valid_i, .host_ready_o, .host_data_i, .host_first_i, .host_rd_i, .host_last_i,
    .word_valid_o (rx_in_valid),
    .word_ready_i (rx_in_ready),
    .word_data_o  (rx_in_data),
    .cmd          (cmd_if.source)
  );

  recovery_fifo #(
    .payload_t (recovery_pkg::word_t),
    .DEPTH     (recovery_pkg::RX_DEPTH)
  ) rx_fifo_i (
    .clk_i, .rst_ni,
    .flush_i     (rx_flush),
    .in_valid_i  (rx_in_valid),
    .in_ready_o  (rx_in_ready),
    .in_data_i   (rx_in_data),
    .out_valid_o (rx_out_valid),
    .out_ready_i (rx_out_ready),
    .out_data_o  (rx_out_data)
  );

  recovery_executor executor_i (
    .clk_i, .rst_ni,
    .cmd          (cmd_if.sink),
    .rx_valid_i   (rx_out_valid),
    .rx_ready_o   (rx_out_ready),
    .rx_data_i    (rx_out_data),
    .rx_flush_o   (rx_flush),
    .wr_en_o      (wr_en),
    .wr_idx_o     (wr_idx),
    .wr_data_o    (wr_data),
    .rd_idx_o     (rd_idx),
    .rd_data_i    (rd_data),
    .status_we_o  (status_we),
    .status_err_o (status_err),
    .tx_valid_o   (tx_in_valid),
    .tx_ready_i   (tx_in_ready),
    .tx_data_o    (tx_in_data)
  );

  recovery_csr_file csr_file_i (
    .clk_i, .rst_ni,
    .wr_en_i      (wr_en),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .rd_idx_i     (rd_idx),
    .rd_data_o    (rd_data),
    .status_we_i  (status_we),
    .status_err_i (status_err)
  );

  // Response queue is never flushed
  recovery_fifo #(
    .payload_t (recovery_pkg::resp_beat_t),
    .DEPTH     (recovery_pkg::TX_DEPTH)
  ) tx_fifo_i (
    .clk_i, .rst_ni,
    .flush_i     (1'b0),
    .in_valid_i  (tx_in_valid),
    .in_ready_o  (tx_in_ready),
    .in_data_i   (tx_in_data),
    .out_valid_o (resp_valid_o),
    .out_ready_i (resp_ready_i),
    .out_data_o  (tx_out_data)
  );

  assign resp_data_o = tx_out_data.data;
  assign resp_last_o = tx_out_data.last;

endmodule

// File: tests/tb_clock_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held low for the first 16 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tests/recovery_checker.sv
// Concurrent handshake, reset and command ordering assertions for the top level
`timescale 1ns/1ps

module recovery_checker (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       host_ready_i,
  input logic       resp_valid_i,
  input logic       resp_ready_i,
  input logic [7:0] resp_data_i,
  input logic       resp_last_i,
  input logic       cmd_valid_i,
  input logic       cmd_done_i
);

  logic stable_fail = 1'b0;
  logic reset_fail  = 1'b0;
  logic done_fail   = 1'b0;
  logic failed;

  assign failed = stable_fail | reset_fail | done_fail;

  // Stalled response beat holds its payload
  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (resp_valid_i && !resp_ready_i) |=>
      (resp_valid_i && $stable(resp_data_i) && $stable(resp_last_i)))
    else begin
      stable_fail = 1'b1;
      $error("Response beat changed while stalled");
    end

  // First cycle out of reset
  reset_state_a: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> (host_ready_i && !resp_valid_i && !cmd_valid_i && !cmd_done_i))
    else begin
      reset_fail = 1'b1;
      $error("Wrong handshake state right after reset");
    end

  done_needs_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_done_i |-> cmd_valid_i)
    else begin
      done_fail = 1'b1;
      $error("Command done without an outstanding command");
    end

endmodule

bind recovery_top recovery_checker protocol_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .host_ready_i (host_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_data_i  (resp_data_o),
  .resp_last_i  (resp_last_o),
  .cmd_valid_i  (cmd_if.valid),
  .cmd_done_i   (cmd_if.done)
);

// File: tests/recovery_tb.sv
// Recovery command layer testbench with frame stimulus, back-pressure and response checks
`timescale 1ns/1ps

module recovery_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rst_n;
  logic       host_valid = 1'b0;
  logic       host_ready;
  logic [7:0] host_data  = 8'h00;
  logic       host_first = 1'b0;
  logic       host_rd    = 1'b0;
  logic       host_last  = 1'b0;
  logic       resp_valid;
  logic       resp_ready = 1'b1;
  logic [7:0] resp_data;
  logic       resp_last;
  logic        bp_en = 1'b0;
  logic [31:0] rng_q = 32'ha12b_1258;
  // Captured beats as {last, data}
  logic [8:0]  rx_q [$];
  logic [8:0]  trace_q [$];
  recovery_pkg::word_t model [recovery_pkg::NUM_CSR];

  tb_clock_gen clock_gen_i (.clk_o(clk), .rst_no(rst_n));

  recovery_top dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .host_valid_i (host_valid),
    .host_ready_o (host_ready),
    .host_data_i  (host_data),
    .host_first_i (host_first),
    .host_rd_i    (host_rd),
    .host_last_i  (host_last),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_data_o  (resp_data),
    .resp_last_o  (resp_last)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    rng_q = xorshift32(rng_q);
    resp_ready <= !bp_en || rng_q[7];
  end

  // A beat seen at the falling edge transfers on the next rising edge
  always @(negedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      rx_q.push_back({resp_last, resp_data});
    end
    if (dut_i.protocol_chk.failed) begin
      stop_run("A protocol assertion in the bound checker failed");
    end
  end

  // Called on a rising edge, returns on the edge that takes the beat
  task automatic send_beat(input logic [7:0] data, input logic first, input logic rd,
                           input logic last);
    int waited;
    waited = 0;
    host_valid <= 1'b1;
    host_data  <= data;
    host_first <= first;
    host_rd    <= rd;
    host_last  <= last;
    @(negedge clk);
    while (!host_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("Host port never became ready");
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_write(input logic [7:0] code, input logic [15:0] len_field,
                           input logic [7:0] data [$], input logic bad_csum);
    logic [7:0] csum;
    csum = code ^ len_field[7:0] ^ len_field[15:8];
    @(posedge clk);
    send_beat(code, 1'b1, 1'b0, 1'b0);
    send_beat(len_field[7:0], 1'b0, 1'b0, 1'b0);
    send_beat(len_field[15:8], 1'b0, 1'b0, 1'b0);
    foreach (data[i]) begin
      send_beat(data[i], 1'b0, 1'b0, 1'b0);
      csum = csum ^ data[i];
    end
    send_beat(bad_csum ? ~csum : csum, 1'b0, 1'b0, 1'b1);
    host_valid <= 1'b0;
  endtask

  task automatic run_read(input logic [7:0] code, output logic [8:0] got [$]);
    int waited;
    waited = 0;
    rx_q = {};
    @(posedge clk);
    send_beat(code, 1'b1, 1'b1, 1'b1);
    host_valid <= 1'b0;
    while (rx_q.size() == 0 || !rx_q[$][8]) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("No last response beat arrived for a read");
      end
    end
    got = rx_q;
  endtask

  // Length bytes, then register bytes from the model, last on the final beat
  task automatic build_expected(input logic [7:0] code, output logic [8:0] exp [$]);
    int k;
    int len;
    int base;
    k    = int'(code) - int'(recovery_pkg::CMD_PROT_CAP);
    len  = 0;
    base = 0;
    exp  = {};
    if (k >= 0 && k < int'(recovery_pkg::NUM_CMD)) begin
      len  = int'(recovery_pkg::CMD_LEN[k]);
      base = int'(recovery_pkg::CMD_BASE[k]);
    end
    exp.push_back({1'b0, 8'(len)});
    exp.push_back({len == 0, 8'(len >> 8)});
    for (int i = 0; i < len; i++) begin
      exp.push_back({i == len - 1, model[base + i / 4][8 * (i % 4) +: 8]});
    end
  endtask

  task automatic record_write(input logic [7:0] code, input logic [7:0] data [$]);
    int base;
    base = int'(recovery_pkg::CMD_BASE[int'(code) - int'(recovery_pkg::CMD_PROT_CAP)]);
    foreach (data[i]) begin
      model[base + i / 4][8 * (i % 4) +: 8] = data[i];
    end
  endtask

  task automatic read_and_check(input logic [7:0] code);
    logic [8:0] exp [$];
    logic [8:0] got [$];
    build_expected(code, exp);
    run_read(code, got);
    assert (got.size() == exp.size())
      else stop_run($sformatf("ERR %0t: command %0d gave %0d beats, expected %0d",
                              $time, code, got.size(), exp.size()));
    foreach (exp[i]) begin
      assert (got[i] == exp[i])
        else stop_run($sformatf("ERR %0t: command %0d beat %0d is %h, expected %h",
                                $time, code, i, got[i], exp[i]));
      trace_q.push_back(got[i]);
    end
  endtask

  // Status byte reflects the command before this read
  task automatic expect_status(input recovery_pkg::proto_err_e err);
    model[recovery_pkg::CSR_DEVICE_STATUS][15:8] = err;
    read_and_check(recovery_pkg::CMD_DEVICE_STATUS);
  endtask

  initial begin
    logic [7:0] bytes_q [$];
    logic [7:0] read_codes [$];
    logic [8:0] first_pass [$];
    int         waited;
    foreach (model[i]) begin
      model[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      model[i] = recovery_pkg::PROT_CAP_VALUE[i];
    end
    model[recovery_pkg::CSR_DEVICE_ID_0]     = recovery_pkg::DEVICE_ID_VALUE[0];
    model[recovery_pkg::CSR_DEVICE_ID_1]     = recovery_pkg::DEVICE_ID_VALUE[1];
    model[recovery_pkg::CSR_RECOVERY_STATUS] = recovery_pkg::RECOVERY_STATUS_RESET;
    model[recovery_pkg::CSR_HW_STATUS]       = recovery_pkg::HW_STATUS_RESET;
    waited = 0;
    while (!rst_n) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("Reset was never released");
      end
    end

    read_and_check(recovery_pkg::CMD_PROT_CAP);

    bytes_q = {8'hA5, 8'h3C, 8'h7E};
    run_write(recovery_pkg::CMD_RECOVERY_CTRL, 16'd3, bytes_q, 1'b0);
    record_write(recovery_pkg::CMD_RECOVERY_CTRL, bytes_q);
    expect_status(recovery_pkg::PROTO_OK);
    read_and_check(recovery_pkg::CMD_RECOVERY_CTRL);
    expect_status(recovery_pkg::PROTO_OK);

    // Read-only target keeps its reset value
    bytes_q = {8'h01, 8'h02, 8'h03, 8'h04};
    run_write(recovery_pkg::CMD_HW_STATUS, 16'd4, bytes_q, 1'b0);
    expect_status(recovery_pkg::PROTO_READ_ONLY);
    read_and_check(recovery_pkg::CMD_HW_STATUS);

    bytes_q = {8'h11, 8'h22, 8'h33};
    run_write(recovery_pkg::CMD_DEVICE_RESET, 16'd3, bytes_q, 1'b0);
    record_write(recovery_pkg::CMD_DEVICE_RESET, bytes_q);
    expect_status(recovery_pkg::PROTO_OK);
    bytes_q = {8'h44, 8'h55, 8'h66};
    run_write(recovery_pkg::CMD_DEVICE_RESET, 16'd3, bytes_q, 1'b1);
    expect_status(recovery_pkg::PROTO_CRC);
    read_and_check(recovery_pkg::CMD_DEVICE_RESET);
    // Length field larger than the data count
    bytes_q = {8'h77, 8'h88};
    run_write(recovery_pkg::CMD_DEVICE_RESET, 16'd3, bytes_q, 1'b0);
    expect_status(recovery_pkg::PROTO_LENGTH);
    // Length beyond the register size
    bytes_q = {8'h01, 8'h02, 8'h03, 8'h04, 8'h05};
    run_write(recovery_pkg::CMD_RECOVERY_CTRL, 16'd5, bytes_q, 1'b0);
    expect_status(recovery_pkg::PROTO_LENGTH);
    read_and_check(recovery_pkg::CMD_DEVICE_RESET);
    read_and_check(recovery_pkg::CMD_RECOVERY_CTRL);

    read_and_check(8'h50);
    expect_status(recovery_pkg::PROTO_PARAMETER);

    // Same reads without and with response back-pressure
    read_codes = {recovery_pkg::CMD_PROT_CAP, recovery_pkg::CMD_DEVICE_ID,
                  recovery_pkg::CMD_DEVICE_RESET, recovery_pkg::CMD_RECOVERY_CTRL,
                  recovery_pkg::CMD_RECOVERY_STATUS, recovery_pkg::CMD_HW_STATUS, 8'h50};
    trace_q = {};
    foreach (read_codes[i]) begin
      read_and_check(read_codes[i]);
    end
    first_pass = trace_q;
    bp_en = 1'b1;
    trace_q = {};
    foreach (read_codes[i]) begin
      read_and_check(read_codes[i]);
    end
    assert (trace_q.size() == first_pass.size())
      else stop_run($sformatf("ERR %0t: %0d beats under back-pressure, %0d without",
                              $time, trace_q.size(), first_pass.size()));
    foreach (first_pass[i]) begin
      assert (trace_q[i] == first_pass[i])
        else stop_run($sformatf("ERR %0t: beat %0d is %h under back-pressure, %h without",
                                $time, i, trace_q[i], first_pass[i]));
    end

    if (dut_i.protocol_chk.failed) begin
      stop_run("A protocol assertion in the bound checker failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: src.f
logic/recovery_pkg.sv
logic/recovery_cmd_if.sv
logic/recovery_fifo.sv
logic/recovery_csr_file.sv
logic/recovery_receiver.sv
logic/recovery_executor.sv
logic/recovery_top.sv
tests/tb_clock_gen.sv
tests/recovery_checker.sv
tests/recovery_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = recovery_tb
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
